/* bench/clut_tb_tasks.svh */
// clut testbench tasks: wishbone and pixel drivers, random numbers and bounded waits.
`ifndef clut_tb_tasks_svh
`define clut_tb_tasks_svh

	// 32-bit xorshift step.
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// table fill word, mixes every address bit.
	function automatic clut_word_t fill_word(input int addr);
		logic [31:0] h;
		h = addr * 32'h9e37_79b1;
		return clut_word_t'(h[31:16] ^ {7'h0, addr[8:0]});
	endfunction

	// back to the drive point, n edges later.
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge sys_clk);
		end
		#1;
	endtask

	// ack is looked at on the falling edge, where it is stable.
	task automatic wait_ack(input string what, output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < ack_timeout) begin
			@(negedge sys_clk);
			ok = wb_rsp.ack;
			cycles++;
		end
		if (!ok) begin
			other_errors++;
			$display("timeout: no ack for %s", what);
		end
	endtask

	task automatic wb_write(input int addr, input clut_word_t data);
		logic done;
		req_seen = 1'b1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b1;
		wb_req.adr = clut_addr_t'(addr);
		wb_req.dat = data;
		wait_ack($sformatf("write at %0d", addr), done);
		if (done) begin
			model[addr] = data; // mirror only completed writes.
		end
		idle(1);
		wb_req = '0;
	endtask

	task automatic wb_read(input int addr);
		logic done;
		req_seen = 1'b1;
		rd_exp = model[addr];
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b0;
		wb_req.adr = clut_addr_t'(addr);
		wb_req.dat = '0;
		wait_ack($sformatf("read at %0d", addr), done);
		idle(1);
		wb_req = '0;
	endtask

	// indices from base to base+span-1; gaps drops about one cycle in four.
	task automatic pix_burst(input int count, input int base, input int span, input bit gaps);
		logic [31:0] r;
		int idx;
		int n;
		n = 0;
		while (n < count) begin
			r = next_rand();
			if (gaps && r[1:0] == 2'b00) begin
				pix_valid = 1'b0;
			end else begin
				idx = base + (int'(r[15:4]) % span);
				req_seen = 1'b1;
				pix_valid = 1'b1;
				pix_index = clut_addr_t'(idx);
				exp_q.push_back(model[idx]);
				n++;
			end
			idle(1);
		end
		pix_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < drain_timeout) begin
			idle(1);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("timeout: %0d pixel colours never came out", exp_q.size());
		end
	endtask

`endif

/* bench/clut_tb.sv */
// clut testbench: drives bus and pixel traffic and checks both against a table model.
`timescale 1ns/1ns
`default_nettype none

module clut_tb
	import clut_pkg::*;
();

	localparam int ack_timeout   = 400;
	localparam int drain_timeout = 50;

	logic       sys_clk;
	logic       arst_n;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;
	logic       pix_valid;
	clut_addr_t pix_index;
	logic       color_valid;
	clut_word_t color;

	clut_word_t  model [0:clut_depth-1];
	clut_word_t  exp_q [$];
	clut_word_t  exp_color;
	clut_word_t  rd_exp;
	logic [31:0] rng_state;
	logic        req_seen;
	string       test_name;
	int          data_errors;
	int          timing_errors;
	int          other_errors;

	// history used by the checks.
	int          stb_age;
	logic        ack_prev;
	logic [2:0]  pv_hist;

	`include "clut_tb_tasks.svh"

	clut_top dut_i (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.pix_valid   (pix_valid),
		.pix_index   (pix_index),
		.color_valid (color_valid),
		.color       (color)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#2 sys_clk = ~sys_clk;
		end
	end

	always @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			stb_age  <= 0;
			ack_prev <= 1'b0;
			pv_hist  <= '0;
		end else begin
			stb_age  <= (!wb_req.stb || wb_rsp.ack) ? 0 : stb_age + 1; // cycles since stb.
			ack_prev <= wb_rsp.ack;
			pv_hist  <= {pv_hist[1:0], pix_valid};
		end
	end

	// oldest expected colour moves out when its colour appears.
	always @(negedge sys_clk) begin
		if (arst_n && color_valid) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("colour output with no pixel pending");
			end else begin
				exp_color = exp_q.pop_front();
			end
		end
	end

	assert property (@(posedge sys_clk) req_seen || (!wb_rsp.ack && !color_valid))
		else begin
			other_errors++;
			$display("ack or color_valid raised before any request");
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n) wb_rsp.ack |-> wb_req.stb)
		else begin
			other_errors++;
			$display("ack seen with no open transfer");
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n) wb_rsp.ack |-> !ack_prev)
		else begin
			timing_errors++;
			$display("error %s: expected ack for one cycle, actual two or more", test_name);
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		(wb_rsp.ack && !wb_req.we) |-> stb_age >= 2)
		else begin
			timing_errors++;
			$display("error %s: expected read ack age >= 2, actual %0d", test_name,
				$sampled(stb_age));
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		(wb_rsp.ack && wb_req.we) |-> stb_age >= 1)
		else begin
			timing_errors++;
			$display("error %s: expected write ack age >= 1, actual %0d", test_name,
				$sampled(stb_age));
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		(wb_rsp.ack && !wb_req.we) |-> wb_rsp.dat == rd_exp)
		else begin
			data_errors++;
			$display("error %s: expected %h, actual %h", test_name, $sampled(rd_exp),
				$sampled(wb_rsp.dat));
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n) color_valid == pv_hist[2])
		else begin
			timing_errors++;
			$display("error %s: expected color_valid %b, actual %b", test_name,
				$sampled(pv_hist[2]), $sampled(color_valid));
		end

	assert property (@(posedge sys_clk) disable iff (!arst_n) color_valid |-> color == exp_color)
		else begin
			data_errors++;
			$display("error %s: expected %h, actual %h", test_name, $sampled(exp_color),
				$sampled(color));
		end

	initial begin
		logic [31:0] r;
		rng_state = 32'd52;
		arst_n = 1'b0;
		wb_req = '0;
		pix_valid = 1'b0;
		pix_index = '0;
		req_seen = 1'b0;
		rd_exp = '0;
		exp_color = '0;
		data_errors = 0;
		timing_errors = 0;
		other_errors = 0;
		test_name = "reset state";
		repeat (2) begin
			@(posedge sys_clk);
		end
		#1;
		arst_n = 1'b1;
		idle(4);

		test_name = "write then read back";
		for (int i = 0; i < clut_depth; i++) begin
			wb_write(i, fill_word(i)); // whole table, so every pixel has a model entry.
		end
		wb_read(0);
		wb_read(clut_depth - 1);
		wb_write(0, 16'hffff);
		wb_read(0);
		wb_write(clut_depth - 1, 16'h0001);
		wb_read(clut_depth - 1);
		for (int i = 0; i < 8; i++) begin
			wb_read(int'(next_rand() & 32'h1ff));
		end

		test_name = "pixel lookup";
		pix_burst(64, 0, clut_depth, 1'b0);
		pix_burst(32, 8, 3, 1'b0); // narrow span, many repeats.
		wait_drained();

		// pixels stay in the lower half, bus traffic in the upper half.
		test_name = "contention";
		fork
			pix_burst(200, 0, 256, 1'b1);
			begin
				for (int i = 0; i < 24; i++) begin
					wb_write(256 + i * 9, clut_word_t'(32'hc000 ^ (i * 37)));
					wb_read(256 + i * 9);
				end
			end
		join
		wait_drained();

		test_name = "random mix";
		for (int i = 0; i < 300; i++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: wb_write(int'(r[12:4]), clut_word_t'(r[31:16]));
				2'd1: wb_read(int'(r[12:4]));
				default: begin
					pix_burst(1 + int'(r[6:4]), 0, clut_depth, r[8]);
					wait_drained();
				end
			endcase
		end

		idle(4);
		$display("errors: data %0d, timing %0d, other %0d", data_errors, timing_errors,
			other_errors);
		if (data_errors + timing_errors + other_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* clut_ram/clut_ram.sv */
// clut RAM: single-port 512 x 16 palette store with registered read and output-enable word.
`timescale 1ns/1ns
`default_nettype none

module clut_ram
	import clut_pkg::*;
(
	output clut_word_t       z_out,
	output clut_word_t       z_oe,
	input  wire clut_word_t  z_in,
	input  wire logic        cen,   // active low chip enable.
	input  wire logic        rw,    // high reads, low writes.
	input  wire clut_addr_t  a,
	input  wire logic        sys_clk,
	input  wire logic        arst_n
);

	// the core uses descending numbering.
	// pin bit n maps to core bit n.
	logic [clut_aw-1:0] a_r;
	logic [clut_dw-1:0] z_in_r;
	logic [clut_dw-1:0] z_out_r;

	logic [clut_dw-1:0] mem [0:clut_depth-1];

	always_comb begin
		for (int i = 0; i < clut_aw; i++) begin
			a_r[i] = a[i];
		end
	end

	always_comb begin
		for (int i = 0; i < clut_dw; i++) begin
			z_in_r[i] = z_in[i];
			z_out[i]  = z_out_r[i];
		end
	end

	// array write and registered read.
	// a write also returns the new word (read-during-write gives new data).
	always_ff @(posedge sys_clk) begin
		if (!cen) begin
			if (!rw) begin
				mem[a_r] <= z_in_r;
				z_out_r  <= z_in_r;
			end else begin
				z_out_r  <= mem[a_r];
			end
		end
	end

	// output-enable word.
	// all ones for exactly one cycle after each read.
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			z_oe <= '0;
		end else if (!cen && rw) begin
			z_oe <= '1; // read issued last cycle.
		end else begin
			z_oe <= '0;
		end
	end

endmodule

`default_nettype wire

/* clut_top.f */
+incdir+bench
common/clut_pkg.sv
clut_ram/clut_ram.sv
hdl/clut_bus_port.sv
hdl/pixel_lookup.sv
hdl/clut_top.sv
bench/clut_tb.sv

/* common/clut_pkg.sv */
// clut package: palette geometry and the bus, RAM-port and pixel request bundles.
`default_nettype none

package clut_pkg;

	// table geometry.
	localparam int clut_depth = 512; // palette entries.
	localparam int clut_aw    = 9;   // address bits.
	localparam int clut_dw    = 16;  // colour word bits.

	// big-endian numbering, as on the RAM pins.
	// bit 0 is the most significant bit.
	typedef logic [0:clut_aw-1] clut_addr_t;
	typedef logic [0:clut_dw-1] clut_word_t;

	// wishbone classic, master to slave.
	// the master holds every field until it sees ack.
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;  // high for a write.
		clut_addr_t adr;
		clut_word_t dat; // write data.
	} wb_req_t;

	// wishbone classic, slave to master.
	typedef struct packed {
		logic       ack; // one cycle per transfer.
		clut_word_t dat; // read data, valid with ack.
	} wb_rsp_t;

	// pixel-side read request to the shared RAM port.
	// a valid request takes the port in the same cycle.
	typedef struct packed {
		logic       valid;
		clut_addr_t index;
	} pix_req_t;

endpackage

`default_nettype wire

/* hdl/clut_bus_port.sv */
// clut bus port: wishbone classic slave sharing the RAM port with pixel reads.
`timescale 1ns/1ns
`default_nettype none

module clut_bus_port
	import clut_pkg::*;
(
	input  wire logic        sys_clk,
	input  wire logic        arst_n,
	input  wire wb_req_t     wb_req,
	output wb_rsp_t          wb_rsp,
	input  wire pix_req_t    pix_req,
	input  wire clut_word_t  z_out,
	input  wire clut_word_t  z_oe,
	output logic             cen,
	output logic             rw,
	output clut_addr_t       a,
	output clut_word_t       z_in
);

	typedef enum logic [1:0] {
		st_idle,
		st_wr_ack,
		st_rd_wait,
		st_rd_ack
	} state_t;

	state_t     state;
	logic       cpu_pending;
	logic       grant;
	logic       rd_ready;
	clut_word_t rd_data;

	// a transfer is open while cyc and stb are both high.
	assign cpu_pending = wb_req.cyc && wb_req.stb;

	// cpu gets the port only when idle and no pixel read is asking.
	// pixel reads always win.
	assign grant = (state == st_idle) && cpu_pending && !pix_req.valid;

	// read data is on z_out once z_oe shows the read completed.
	assign rd_ready = (state == st_rd_wait) && (|z_oe);

	// shared RAM port mux.
	always_comb begin
		if (pix_req.valid) begin
			cen = 1'b0;
			rw  = 1'b1; // pixel side only reads.
			a   = pix_req.index;
		end else begin
			cen = !grant;
			rw  = !wb_req.we;
			a   = wb_req.adr;
		end
		z_in = wb_req.dat; // only sampled on a cpu write.
	end

	// transfer sequencing.
	// write: grant, ack.
	// read: grant, wait for data, ack.
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (grant) begin
						state <= wb_req.we ? st_wr_ack : st_rd_wait;
					end
				end
				st_wr_ack: begin
					state <= st_idle; // master may start again next cycle.
				end
				st_rd_wait: begin
					if (rd_ready) begin
						state <= st_rd_ack;
					end
				end
				st_rd_ack: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// hold the read word for the ack cycle.
	always_ff @(posedge sys_clk) begin
		if (rd_ready) begin
			rd_data <= z_out;
		end
	end

	// response to the master.
	always_comb begin
		wb_rsp.ack = (state == st_wr_ack) || (state == st_rd_ack);
		wb_rsp.dat = rd_data;
	end

endmodule

`default_nettype wire

/* hdl/clut_top.sv */
// clut top: bus port, palette RAM and pixel lookup around one shared RAM port.
`timescale 1ns/1ns
`default_nettype none

module clut_top
	import clut_pkg::*;
(
	input  wire logic        sys_clk,
	input  wire logic        arst_n,
	input  wire wb_req_t     wb_req,
	output wb_rsp_t          wb_rsp,
	input  wire logic        pix_valid,
	input  wire clut_addr_t  pix_index,
	output logic             color_valid,
	output clut_word_t       color
);

	// shared RAM port.
	pix_req_t   pix_req;
	clut_word_t z_out;
	clut_word_t z_oe;
	clut_word_t z_in;
	logic       cen;
	logic       rw;
	clut_addr_t a;

	// producer of table contents, and port arbiter.
	clut_bus_port bus_port_i (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.pix_req (pix_req),
		.z_out   (z_out),
		.z_oe    (z_oe),
		.cen     (cen),
		.rw      (rw),
		.a       (a),
		.z_in    (z_in)
	);

	// palette store.
	clut_ram ram_i (
		.z_out   (z_out),
		.z_oe    (z_oe),
		.z_in    (z_in),
		.cen     (cen),
		.rw      (rw),
		.a       (a),
		.sys_clk (sys_clk),
		.arst_n  (arst_n)
	);

	// consumer, video side.
	pixel_lookup pixel_lookup_i (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.pix_valid   (pix_valid),
		.pix_index   (pix_index),
		.pix_req     (pix_req),
		.z_out       (z_out),
		.color_valid (color_valid),
		.color       (color)
	);

endmodule

`default_nettype wire

/* hdl/pixel_lookup.sv */
// pixel lookup: three-stage pipeline turning pixel indices into palette colours.
`timescale 1ns/1ns
`default_nettype none

module pixel_lookup
	import clut_pkg::*;
(
	input  wire logic        sys_clk,
	input  wire logic        arst_n,
	input  wire logic        pix_valid,
	input  wire clut_addr_t  pix_index,
	output pix_req_t         pix_req,
	input  wire clut_word_t  z_out,
	output logic             color_valid,
	output clut_word_t       color
);

	// stage one holds the index presented to the RAM.
	logic       s1_valid;
	clut_addr_t s1_index;

	// stage two follows the RAM's own read register.
	logic       s2_valid;

	// stage one.
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pix_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pix_valid) begin
			s1_index <= pix_index;
		end
	end

	// request straight from the stage-one register.
	// the bus port gives it the RAM in this cycle.
	always_comb begin
		pix_req.valid = s1_valid;
		pix_req.index = s1_index;
	end

	// stage two.
	// z_out carries the entry while s2_valid is high.
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	// stage three.
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			color_valid <= 1'b0;
		end else begin
			color_valid <= s2_valid; // three cycles after pix_valid.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (s2_valid) begin
			color <= z_out;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the clut testbench with verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module clut_tb -f clut_top.f -o clut_sim \
	&& ./obj_dir/clut_sim > sim.log 2>&1 \
	|| echo "build or simulation stopped early"

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
	&& echo "result: pass" \
	|| { echo "result: fail"; exit 1; }
